//--- verilog/issue_defines.svh
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// queue geometry
`define IQ_DEPTH        8       // entries as a power of two
`define FETCH_WIDTH     4       // lanes per fetch packet

// issue mode codes
`define ISSUE_NONE      2'd0
`define ISSUE_SINGLE    2'd1
`define ISSUE_DUAL      2'd2

// MIPS primary opcodes
`define OP_SPECIAL      6'h00   // R-type decided by funct
`define OP_J            6'h02
`define OP_JAL          6'h03
`define OP_BEQ          6'h04
`define OP_BNE          6'h05
`define OP_ALUI_LO      6'h08   // addi .. lui
`define OP_ALUI_HI      6'h0F
`define OP_LOAD_LO      6'h20   // lb .. lhu
`define OP_LOAD_HI      6'h25
`define OP_STORE_LO     6'h28   // sb .. sw
`define OP_STORE_HI     6'h2B
`define FN_MULDIV_LO    6'h18   // mult, multu, div, divu
`define FN_MULDIV_HI    6'h1B

`endif

//--- verilog/issuePkg.sv
`include "issue_defines.svh"

package issuePkg;

    // plain vectors with a meaning
    typedef logic [31:0] word_t;        // instruction or address
    typedef logic [4:0]  regNum_t;      // GPR number
    typedef logic [4:0]  excCode_t;     // CP0 exception code
    typedef logic [1:0]  issueMode_t;   // NONE / SINGLE / DUAL

    //////////////////////////////
    // fetch packet per I-cache return
    typedef struct packed {
        word_t [`FETCH_WIDTH-1:0] inst;
        word_t [`FETCH_WIDTH-1:0] predTarget;   // predicted target per lane
        logic  [`FETCH_WIDTH-1:0] predTaken;
        logic  [`FETCH_WIDTH-1:0] laneEn;       // sparse lanes allowed
        word_t                    basePc;       // PC of lane 0
        logic                     hasExc;       // whole packet
        excCode_t                 excCode;
    } fetchPacket_t;

    // one queue slot
    typedef struct packed {
        word_t    inst;
        word_t    pc;
        word_t    predTarget;
        logic     predTaken;
        logic     hasExc;
        excCode_t excCode;
    } iqEntry_t;

    // register usage and class of one instruction
    typedef struct packed {
        regNum_t [1:0] readReg;     // [0] rs, [1] rt
        logic    [1:0] readNeed;
        regNum_t       writeReg;
        logic          writeNeed;   // never set for r0
        logic          isBranch;    // branches and jumps
        logic          isMulDiv;
    } decodedInst_t;

    // what decode receives per slot
    typedef struct packed {
        iqEntry_t     entry;
        decodedInst_t dec;
    } issueSlot_t;

endpackage

//--- verilog/instQueue.sv
`include "issue_defines.svh"

module instQueue
    import issuePkg::*;
(
    input  logic           clk,
    input  logic           arstN_i,

    //////////////////////////////
    // fetch side
    input  fetchPacket_t   fetch_i,
    input  logic           fetchValid_i,
    output logic           stopFetch_o,     // fewer than FETCH_WIDTH free

    // pipeline control
    input  logic           flush_i,
    input  logic           excOccur_i,
    input  logic           idAllowin_i,     // decode can take this cycle
    input  issueMode_t     issueMode_i,     // from arbiter to set pop count

    //////////////////////////////
    // head of queue with slot 0 oldest
    output iqEntry_t [1:0] headEntry_o,
    output logic [1:0]     headValid_o
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;       // one extra bit for full

    iqEntry_t mem [`IQ_DEPTH];              // entry payload

    ptr_t     headPtr;
    ptr_t     tailPtr;
    ptr_t     nextHead;                     // second head entry
    cnt_t     count;                        // occupancy

    ptr_t     wrIdx [`FETCH_WIDTH];         // target slot per lane
    iqEntry_t laneEntry [`FETCH_WIDTH];
    cnt_t     laneCnt;                      // enabled lanes in packet
    cnt_t     pushNum;
    cnt_t     popNum;
    logic     pushEn;
    logic     flushEn;

    assign flushEn = flush_i | excOccur_i;
    assign pushEn  = fetchValid_i & ~stopFetch_o;   // ignored while stopped

    //////////////////////////////
    // lane compaction
    // enabled lanes land on consecutive slots from the tail
    // while the PC keeps the original lane position
    always_comb begin
        ptr_t run;
        run = '0;
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
            wrIdx[k]                = tailPtr + run;     // wraps with pointer width
            laneEntry[k].inst       = fetch_i.inst[k];
            laneEntry[k].pc         = fetch_i.basePc + word_t'(4 * k);
            laneEntry[k].predTarget = fetch_i.predTarget[k];
            laneEntry[k].predTaken  = fetch_i.predTaken[k];
            laneEntry[k].hasExc     = fetch_i.hasExc;    // shared by all lanes
            laneEntry[k].excCode    = fetch_i.excCode;
            run = run + ptr_t'(fetch_i.laneEn[k]);
        end
        laneCnt = cnt_t'(run);
    end

    assign pushNum = pushEn ? laneCnt : '0;

    // pop count when decode lets us
    always_comb begin
        popNum = '0;
        if (idAllowin_i) begin
            case (issueMode_i)
                `ISSUE_SINGLE: popNum = cnt_t'(headValid_o[0]);
                `ISSUE_DUAL:   popNum = headValid_o[1] ? cnt_t'(2) : cnt_t'(headValid_o[0]);
                default:       popNum = '0;
            endcase
        end
    end

    //////////////////////////////
    // pointers and count
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else if (flushEn) begin
            // flush wins over push and pop
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            headPtr <= headPtr + ptr_t'(popNum);
            tailPtr <= tailPtr + ptr_t'(pushNum);
            count   <= count + pushNum - popNum;
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (pushEn && !flushEn) begin
            for (int k = 0; k < `FETCH_WIDTH; k++) begin
                if (fetch_i.laneEn[k]) begin
                    mem[wrIdx[k]] <= laneEntry[k];
                end
            end
        end
    end

    //////////////////////////////
    // head view and status from registered state
    assign nextHead = headPtr + ptr_t'(1);

    assign headEntry_o[0] = mem[headPtr];
    assign headEntry_o[1] = mem[nextHead];

    assign headValid_o[0] = (count != '0);
    assign headValid_o[1] = (count > cnt_t'(1));

    assign stopFetch_o = (count > cnt_t'(`IQ_DEPTH - `FETCH_WIDTH));

endmodule

//--- verilog/slotDecoder.sv
`include "issue_defines.svh"

module slotDecoder
    import issuePkg::*;
(
    input  iqEntry_t     entry_i,
    output decodedInst_t decoded_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regNum_t    rs;
    regNum_t    rt;
    regNum_t    rd;
    regNum_t    wrReg;      // destination before r0 filter
    logic       wrNeed;

    // instruction fields
    assign opcode = entry_i.inst[31:26];
    assign funct  = entry_i.inst[5:0];
    assign rs     = entry_i.inst[25:21];
    assign rt     = entry_i.inst[20:16];
    assign rd     = entry_i.inst[15:11];

    always_comb begin
        decoded_o = '0;
        wrReg     = '0;
        wrNeed    = 1'b0;
        if (opcode == `OP_SPECIAL) begin
            decoded_o.readNeed = 2'b11;
            if (funct >= `FN_MULDIV_LO && funct <= `FN_MULDIV_HI) begin
                decoded_o.isMulDiv = 1'b1;      // writes hi/lo and no GPR
            end else begin
                wrReg  = rd;
                wrNeed = 1'b1;
            end
        end else if ((opcode >= `OP_ALUI_LO && opcode <= `OP_ALUI_HI) ||
                     (opcode >= `OP_LOAD_LO && opcode <= `OP_LOAD_HI)) begin
            decoded_o.readNeed = 2'b01;         // rs only
            wrReg  = rt;
            wrNeed = 1'b1;
        end else if (opcode >= `OP_STORE_LO && opcode <= `OP_STORE_HI) begin
            decoded_o.readNeed = 2'b11;         // base and data
        end else if (opcode == `OP_BEQ || opcode == `OP_BNE) begin
            decoded_o.readNeed = 2'b11;
            decoded_o.isBranch = 1'b1;
        end else if (opcode == `OP_J) begin
            decoded_o.isBranch = 1'b1;
        end else if (opcode == `OP_JAL) begin
            decoded_o.isBranch = 1'b1;
            wrReg  = 5'd31;                     // link register
            wrNeed = 1'b1;
        end

        // unused register numbers read as zero
        decoded_o.readReg[0] = decoded_o.readNeed[0] ? rs : '0;
        decoded_o.readReg[1] = decoded_o.readNeed[1] ? rt : '0;

        // write to r0 is no write
        decoded_o.writeNeed = wrNeed & (wrReg != '0);
        decoded_o.writeReg  = decoded_o.writeNeed ? wrReg : '0;
    end

endmodule

//--- verilog/issueArbiter.sv
`include "issue_defines.svh"

module issueArbiter
    import issuePkg::*;
(
    //////////////////////////////
    // queue head and its decode
    input  iqEntry_t     [1:0] headEntry_i,
    input  logic         [1:0] headValid_i,
    input  decodedInst_t [1:0] decoded_i,

    //////////////////////////////
    // to decode stage
    output issueMode_t         issueMode_o,
    output issueSlot_t   [1:0] issueSlot_o  // slot 1 only meaningful under DUAL
);

    logic rawHazard;    // slot 1 reads what slot 0 writes
    logic bothMulDiv;   // single hi/lo unit
    logic anyExc;
    logic dualOk;

    // RAW check where r0 is never a hazard
    always_comb begin
        rawHazard = 1'b0;
        if (decoded_i[0].writeNeed && decoded_i[0].writeReg != '0) begin
            for (int r = 0; r < 2; r++) begin
                if (decoded_i[1].readNeed[r] &&
                    decoded_i[1].readReg[r] == decoded_i[0].writeReg) begin
                    rawHazard = 1'b1;
                end
            end
        end
    end

    assign bothMulDiv = decoded_i[0].isMulDiv & decoded_i[1].isMulDiv;
    assign anyExc     = headEntry_i[0].hasExc | headEntry_i[1].hasExc;

    // only a branch in slot 1 blocks DUAL
    assign dualOk = (&headValid_i)
                  & ~anyExc
                  & ~decoded_i[1].isBranch
                  & ~bothMulDiv
                  & ~rawHazard;

    // mode select independent of allow-in
    always_comb begin
        if (!headValid_i[0]) begin
            issueMode_o = `ISSUE_NONE;      // empty queue
        end else if (dualOk) begin
            issueMode_o = `ISSUE_DUAL;
        end else begin
            issueMode_o = `ISSUE_SINGLE;
        end
    end

    // outgoing bundle of entry plus its decode
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            issueSlot_o[i].entry = headEntry_i[i];
            issueSlot_o[i].dec   = decoded_i[i];
        end
    end

endmodule

//--- verilog/issueStage.sv
module issueStage
    import issuePkg::*;
(
    input  logic             clk,
    input  logic             arstN_i,

    // fetch side
    input  fetchPacket_t     fetch_i,
    input  logic             fetchValid_i,
    output logic             stopFetch_o,

    // pipeline control
    input  logic             flush_i,
    input  logic             excOccur_i,
    input  logic             idAllowin_i,

    // to decode
    output issueMode_t       issueMode_o,
    output issueSlot_t [1:0] issueSlot_o
);

    iqEntry_t     [1:0] headEntry;    // slot 0 oldest
    logic         [1:0] headValid;
    decodedInst_t [1:0] decoded;

    instQueue instQueue_u (
        .clk          (clk),
        .arstN_i      (arstN_i),
        .fetch_i      (fetch_i),
        .fetchValid_i (fetchValid_i),
        .stopFetch_o  (stopFetch_o),
        .flush_i      (flush_i),
        .excOccur_i   (excOccur_i),
        .idAllowin_i  (idAllowin_i),
        .issueMode_i  (issueMode_o),  // pop feedback
        .headEntry_o  (headEntry),
        .headValid_o  (headValid)
    );

    // one decoder per issue slot
    for (genvar i = 0; i < 2; i++) begin : genDecoder
        slotDecoder slotDecoder_u (
            .entry_i   (headEntry[i]),
            .decoded_o (decoded[i])
        );
    end

    issueArbiter issueArbiter_u (
        .headEntry_i (headEntry),
        .headValid_i (headValid),
        .decoded_i   (decoded),
        .issueMode_o (issueMode_o),
        .issueSlot_o (issueSlot_o)
    );

endmodule

//--- tb/issueStageTb.sv
`include "issue_defines.svh"

module issueStageTb
    import issuePkg::*;
();

    //////////////////////////////
    // stimulus table row
    typedef struct packed {
        word_t [3:0] inst;      // RND lanes get a random independent addiu
        logic  [3:0] laneEn;
        logic        hasExc;
        int          nPkt;      // packets sent with allow-in low
        int          flushKind; // 0 none, 1 flush_i, 2 excOccur_i on last packet
    } testRow_t;

    localparam word_t RND = 32'hFFFF_FFFF;   // opcode 0x3f is never decoded

    logic             clk;
    logic             arstN_i;
    fetchPacket_t     fetch_i;
    logic             fetchValid_i;
    logic             flush_i;
    logic             excOccur_i;
    logic             idAllowin_i;
    logic             stopFetch_o;
    issueMode_t       issueMode_o;
    issueSlot_t [1:0] issueSlot_o;

    testRow_t rows [10];
    string    names [10];
    string    expSeq [10];      // one char S or D per issue cycle
    int       nRows = 0;
    int       errCnt = 0;
    integer   seed = 32'h0876_4a4e;
    iqEntry_t mq [$];           // reference queue with oldest first

    issueStage issueStage_inst (
        .clk          (clk),
        .arstN_i      (arstN_i),
        .fetch_i      (fetch_i),
        .fetchValid_i (fetchValid_i),
        .stopFetch_o  (stopFetch_o),
        .flush_i      (flush_i),
        .excOccur_i   (excOccur_i),
        .idAllowin_i  (idAllowin_i),
        .issueMode_o  (issueMode_o),
        .issueSlot_o  (issueSlot_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // instruction encoders
    function automatic word_t encR(regNum_t rs, regNum_t rt, regNum_t rd, logic [5:0] fn);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encI(logic [5:0] op, regNum_t rs, regNum_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // addiu reading r0..r15 and writing r16..r31 so pairs never collide
    function automatic word_t randAlu();
        word_t r;
        r = $random(seed);
        return {6'h09, 1'b0, r[3:0], 1'b1, r[7:4], r[31:16]};
    endfunction

    function automatic fetchPacket_t mkPacket(int r, int p);
        fetchPacket_t pk;
        word_t        base;
        base = 32'h0040_0000 + word_t'(r * 256 + p * 16);
        pk   = '0;
        for (int k = 0; k < 4; k++) begin
            pk.inst[k]       = (rows[r].inst[k] == RND) ? randAlu() : rows[r].inst[k];
            pk.predTarget[k] = base + 32'h200 + word_t'(k * 8);
        end
        pk.predTaken = 4'b1010;
        pk.laneEn    = rows[r].laneEn;
        pk.basePc    = base;
        pk.hasExc    = rows[r].hasExc;
        pk.excCode   = rows[r].hasExc ? 5'h0c : 5'h00;
        return pk;
    endfunction

    //////////////////////////////
    // reference decode and issue rules
    function automatic decodedInst_t refDecode(word_t w);
        decodedInst_t d;
        logic [5:0]   op;
        regNum_t      wr;
        logic         wn;
        d  = '0;
        op = w[31:26];
        wr = 5'd0;
        wn = 1'b0;
        case (op)
            `OP_SPECIAL: begin
                d.readNeed = 2'b11;
                if (w[5:0] inside {[`FN_MULDIV_LO:`FN_MULDIV_HI]}) begin
                    d.isMulDiv = 1'b1;              // hi/lo target
                end else begin
                    wr = w[15:11];
                    wn = 1'b1;
                end
            end
            `OP_J:   d.isBranch = 1'b1;
            `OP_JAL: begin
                d.isBranch = 1'b1;
                wr = 5'd31;
                wn = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                d.readNeed = 2'b11;
                d.isBranch = 1'b1;
            end
            default: begin
                if (op inside {[`OP_ALUI_LO:`OP_ALUI_HI], [`OP_LOAD_LO:`OP_LOAD_HI]}) begin
                    d.readNeed = 2'b01;
                    wr = w[20:16];
                    wn = 1'b1;
                end else if (op inside {[`OP_STORE_LO:`OP_STORE_HI]}) begin
                    d.readNeed = 2'b11;
                end
            end
        endcase
        d.readReg[0] = d.readNeed[0] ? w[25:21] : 5'd0;
        d.readReg[1] = d.readNeed[1] ? w[20:16] : 5'd0;
        d.writeNeed  = wn && (wr != 5'd0);          // r0 write dropped
        d.writeReg   = d.writeNeed ? wr : 5'd0;
        return d;
    endfunction

    function automatic issueMode_t refMode();
        decodedInst_t d0;
        decodedInst_t d1;
        logic         raw;
        if (mq.size() == 0) return `ISSUE_NONE;
        if (mq.size() == 1) return `ISSUE_SINGLE;
        d0  = refDecode(mq[0].inst);
        d1  = refDecode(mq[1].inst);
        raw = d0.writeNeed && ((d1.readNeed[0] && d1.readReg[0] == d0.writeReg) ||
                               (d1.readNeed[1] && d1.readReg[1] == d0.writeReg));
        if (mq[0].hasExc || mq[1].hasExc || d1.isBranch || (d0.isMulDiv && d1.isMulDiv) || raw)
            return `ISSUE_SINGLE;
        return `ISSUE_DUAL;
    endfunction

    task automatic modelPush(fetchPacket_t pk);
        iqEntry_t e;
        for (int k = 0; k < 4; k++) begin
            if (pk.laneEn[k]) begin
                e.inst       = pk.inst[k];
                e.pc         = pk.basePc + word_t'(4 * k);  // original lane position
                e.predTarget = pk.predTarget[k];
                e.predTaken  = pk.predTaken[k];
                e.hasExc     = pk.hasExc;
                e.excCode    = pk.excCode;
                mq.push_back(e);
            end
        end
    endtask

    task automatic addRow(string nm, word_t i0, word_t i1, word_t i2, word_t i3,
                          logic [3:0] en, logic exc, int np, int fk, string seq);
        rows[nRows].inst      = {i3, i2, i1, i0};
        rows[nRows].laneEn    = en;
        rows[nRows].hasExc    = exc;
        rows[nRows].nPkt      = np;
        rows[nRows].flushKind = fk;
        names[nRows]          = nm;
        expSeq[nRows]         = seq;
        nRows++;
    endtask

    //////////////////////////////
    // drive and check
    task automatic sendPacket(int r, fetchPacket_t pk, int fk);
        logic expStop;
        @(posedge clk);
        fetch_i      <= pk;
        fetchValid_i <= 1'b1;
        flush_i      <= (fk == 1);
        excOccur_i   <= (fk == 2);
        expStop = (mq.size() > `IQ_DEPTH - `FETCH_WIDTH);  // fewer than four free
        @(negedge clk);
        if (stopFetch_o !== expStop) begin
            $display("[ERROR] test %0d stopFetch_o: got %h expected %h", r, stopFetch_o,
                     expStop);
            errCnt++;
        end
        @(posedge clk);
        fetchValid_i <= 1'b0;
        flush_i      <= 1'b0;
        excOccur_i   <= 1'b0;
        if (fk != 0)
            mq.delete();                    // flush beats the push
        else if (!expStop)
            modelPush(pk);
    endtask

    task automatic checkSlot(int r, int s);
        decodedInst_t expDec;
        expDec = refDecode(mq[s].inst);
        if (issueSlot_o[s].entry !== mq[s]) begin
            $display("[ERROR] test %0d issueSlot_o[%0d].entry: got %h expected %h",
                     r, s, issueSlot_o[s].entry, mq[s]);
            errCnt++;
        end
        if (issueSlot_o[s].dec !== expDec) begin
            $display("[ERROR] test %0d issueSlot_o[%0d].dec: got %h expected %h",
                     r, s, issueSlot_o[s].dec, expDec);
            errCnt++;
        end
    endtask

    task automatic checkIdle(int r);
        @(negedge clk);
        if (issueMode_o !== `ISSUE_NONE) begin
            $display("[ERROR] test %0d issueMode_o: got %h expected %h", r, issueMode_o,
                     `ISSUE_NONE);
            errCnt++;
        end
        if (stopFetch_o !== 1'b0) begin
            $display("[ERROR] test %0d stopFetch_o: got %h expected 0", r, stopFetch_o);
            errCnt++;
        end
    endtask

    // allow-in high until the model queue is empty with one compare per cycle
    task automatic drainQueue(int r);
        issueMode_t expMode;
        issueMode_t tblMode;
        int         n;
        int         cyc;
        n   = 0;
        cyc = 0;
        idAllowin_i <= 1'b1;
        while (mq.size() > 0 && cyc < 40) begin
            @(negedge clk);
            cyc++;
            expMode = refMode();
            tblMode = expMode;
            if (n < expSeq[r].len()) begin
                tblMode = (expSeq[r][n] == "D") ? `ISSUE_DUAL : `ISSUE_SINGLE;
            end else begin
                $display("test %0d: more issue cycles than the table lists", r);
                errCnt++;
            end
            if (issueMode_o !== expMode) begin
                $display("[ERROR] test %0d issueMode_o: got %h expected %h (model)",
                         r, issueMode_o, expMode);
                errCnt++;
            end
            if (issueMode_o !== tblMode) begin
                $display("[ERROR] test %0d issueMode_o: got %h expected %h (table)",
                         r, issueMode_o, tblMode);
                errCnt++;
            end
            checkSlot(r, 0);
            if (expMode == `ISSUE_DUAL)
                checkSlot(r, 1);
            @(posedge clk);                 // pop edge
            void'(mq.pop_front());
            if (expMode == `ISSUE_DUAL)
                void'(mq.pop_front());
            n++;
        end
        idAllowin_i <= 1'b0;
        if (mq.size() > 0) begin
            $display("test %0d: timeout, queue did not drain", r);
            errCnt++;
        end else if (n != expSeq[r].len()) begin
            $display("test %0d: drained in %0d issue cycles, table lists %0d", r, n,
                     expSeq[r].len());
            errCnt++;
        end
    endtask

    //////////////////////////////
    // main sequence
    initial begin
        int startErr;
        int failTests;
        failTests    = 0;
        arstN_i      = 1'b0;
        fetch_i      = '0;
        fetchValid_i = 1'b0;
        flush_i      = 1'b0;
        excOccur_i   = 1'b0;
        idAllowin_i  = 1'b0;

        addRow("alu pairs", RND, RND, RND, RND, 4'b1111, 1'b0, 1, 0, "DD");
        addRow("sparse lanes", RND, RND, RND, RND, 4'b1101, 1'b0, 1, 0, "DS");
        addRow("raw hazard and r0",                      // i1 reads r3 and writes r0
               encR(5'd1, 5'd2, 5'd3, 6'h21), encR(5'd3, 5'd4, 5'd0, 6'h21),
               encR(5'd0, 5'd0, 5'd6, 6'h21), encR(5'd6, 5'd5, 5'd7, 6'h21),
               4'b1111, 1'b0, 1, 0, "SDS");
        addRow("branch slot 0, mul/div pair",
               encI(`OP_BEQ, 5'd1, 5'd2, 16'h0004), encR(5'd4, 5'd5, 5'd3, 6'h21),
               encR(5'd6, 5'd7, 5'd0, 6'h18), encR(5'd8, 5'd9, 5'd0, 6'h1A),
               4'b1111, 1'b0, 1, 0, "DSS");
        addRow("branch slot 1",
               encR(5'd2, 5'd3, 5'd1, 6'h21), {`OP_J, 26'h010_0040},
               {`OP_JAL, 26'h010_0080}, encI(6'h2B, 5'd9, 5'd8, 16'h0000),
               4'b1111, 1'b0, 1, 0, "SSD");
        addRow("exception packet", RND, RND, RND, RND, 4'b1110, 1'b1, 1, 0, "SSS");
        addRow("back-pressure", RND, RND, RND, RND, 4'b1111, 1'b0, 3, 0, "DDDD");
        addRow("flush", RND, RND, RND, RND, 4'b1111, 1'b0, 2, 1, "");
        addRow("exception flush", RND, RND, RND, RND, 4'b0011, 1'b0, 2, 2, "");

        repeat (10) @(posedge clk);
        arstN_i <= 1'b1;

        for (int r = 0; r < nRows; r++) begin
            startErr = errCnt;
            if (r == 0)
                checkIdle(r);               // state right after reset
            for (int p = 0; p < rows[r].nPkt; p++) begin
                sendPacket(r, mkPacket(r, p),
                           (p == rows[r].nPkt - 1) ? rows[r].flushKind : 0);
            end
            if (mq.size() == 0)
                checkIdle(r);               // cycle after the flush edge
            drainQueue(r);
            checkIdle(r);
            if (errCnt != startErr)
                failTests++;
            $display("test %0d %s: %s", r, names[r], (errCnt == startErr) ? "ok" : "FAILED");
        end

        $display("tests %0d, failed %0d, errors %0d", nRows, failTests, errCnt);
        if (errCnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // whole-run limit
    initial begin
        repeat (4000) @(posedge clk);
        $display("run stopped, cycle limit reached");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/issuePkg.sv
verilog/instQueue.sv
verilog/slotDecoder.sv
verilog/issueArbiter.sv
verilog/issueStage.sv
tb/issueStageTb.sv

//--- runSim.sh
#!/bin/sh
# build the issue stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module issueStageTb -o issueSim > build.log 2>&1 \
    && ./obj_dir/issueSim > sim.log 2>&1 \
    || { cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
